// ==== Makefile ====
# Verilator flow for the out-of-order core testbench.
VERILATOR  ?= verilator
TOP        ?= tb_ooo_core
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG   ?= Regression passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/arch_reg_file.sv ====
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                             clk,
    input  logic                             reset,
    input  ooo_pkg::commit_t                 commit,
    input  logic [ooo_pkg::reg_addr_len-1:0] rd_addr,
    output logic [ooo_pkg::xlen-1:0]         rd_data
);

    import ooo_pkg::*;

    localparam int num_regs = 2 ** reg_addr_len;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.wb_en) begin
            regs[commit.wb_reg] <= commit.wb_data;
        end
    end

    // a write on this edge is visible on the read port from the next cycle.
    assign rd_data = regs[rd_addr];

endmodule

// ==== rtl/dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic rob_full,
    input  logic fifo_full,
    input  logic flush,
    output logic ack,
    output logic dispatch
);

    typedef enum logic {
        st_idle,
        st_acking
    } state_t;

    state_t state;
    logic   admit;

    // a request is admitted only when both the ROB and the issue FIFO have a free slot.
    assign admit = cyc && stb && we && !rob_full && !fifo_full && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (admit) begin
                        state <= st_acking;
                    end
                end
                default: begin
                    // a withheld ack drops back to idle, and the held request is retried.
                    state <= st_idle;
                end
            endcase
        end
    end

    // a flush in the acking cycle withholds the ack so the op is not lost in the clear.
    assign ack = (state == st_acking) && !flush;
    assign dispatch = ack;

    a_ack_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        ack |-> (cyc && stb)
    );

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               empty,
    input  ooo_pkg::issue_op_t head_op,
    output logic               pop,
    output ooo_pkg::cdb_t      cdb
);

    import ooo_pkg::*;

    logic                   busy;
    logic [1:0]             timer;
    logic                   done;
    logic [rob_tag_len-1:0] tag;
    logic [xlen-1:0]        result;
    logic [xlen-1:0]        alu_out;
    logic [1:0]             timer_load;

    // the timer is loaded with latency minus one, so an add reports in the very next cycle.
    always_comb begin
        case (head_op.req.alu_op)
            alu_add: begin
                alu_out = head_op.req.op_a + head_op.req.op_b;
                timer_load = 2'd0;
            end
            alu_sub: begin
                alu_out = head_op.req.op_a - head_op.req.op_b;
                timer_load = 2'd0;
            end
            alu_xor: begin
                alu_out = head_op.req.op_a ^ head_op.req.op_b;
                timer_load = 2'd1;
            end
            default: begin
                alu_out = head_op.req.op_a * head_op.req.op_b;
                timer_load = 2'd3;
            end
        endcase
    end

    assign done = busy && (timer == 2'd0);

    // the next op can be taken on the same edge that ends the broadcast.
    assign pop = (!busy || done) && !empty && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            timer <= 2'd0;
        end else if (pop) begin
            busy <= 1'b1;
            timer <= timer_load;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            timer <= timer - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            tag <= head_op.tag;
            result <= alu_out;
        end
    end

    assign cdb.valid = done;
    assign cdb.tag = tag;
    assign cdb.result = result;

endmodule

// ==== rtl/issue_fifo.sv ====
`timescale 1ns/1ps

module issue_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               push,
    input  ooo_pkg::issue_op_t push_op,
    input  logic               pop,
    output ooo_pkg::issue_op_t head_op,
    output logic               empty,
    output logic               full
);

    import ooo_pkg::*;

    localparam int ptr_len = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_len = $clog2(fifo_depth + 1);
    localparam logic [ptr_len-1:0] last_ptr = ptr_len'(fifo_depth - 1);
    localparam logic [cnt_len-1:0] full_count = cnt_len'(fifo_depth);

    issue_op_t          mem [fifo_depth];
    logic [ptr_len-1:0] rd_ptr;
    logic [ptr_len-1:0] wr_ptr;
    logic [cnt_len-1:0] count;

    assign head_op = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == full_count);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    );

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    );

endmodule

// ==== rtl/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int rob_size   = ooo_pkg::rob_size,
    parameter int fifo_depth = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cyc,
    input  logic                             stb,
    input  logic                             we,
    input  ooo_pkg::dispatch_req_t           dat,
    output logic                             ack,
    output ooo_pkg::commit_t                 commit,
    output logic                             flush,
    input  logic [ooo_pkg::reg_addr_len-1:0] rd_addr,
    output logic [ooo_pkg::xlen-1:0]         rd_data
);

    import ooo_pkg::*;

    logic                   dispatch;
    logic                   rob_full;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   pop;
    logic [rob_tag_len-1:0] rob_tag;
    issue_op_t              push_op;
    issue_op_t              head_op;
    cdb_t                   cdb;

    // the accepted op travels to the issue FIFO together with the tag it was given.
    assign push_op.req = dat;
    assign push_op.tag = rob_tag;

    dispatch_ctrl i_dispatch_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .rob_full  (rob_full),
        .fifo_full (fifo_full),
        .flush     (flush),
        .ack       (ack),
        .dispatch  (dispatch)
    );

    reorder_buffer #(
        .rob_size (rob_size)
    ) i_reorder_buffer (
        .clk         (clk),
        .reset       (reset),
        .dispatch    (dispatch),
        .dispatch_op (dat),
        .cdb         (cdb),
        .rob_tag     (rob_tag),
        .rob_full    (rob_full),
        .commit      (commit),
        .flush       (flush)
    );

    issue_fifo #(
        .fifo_depth (fifo_depth)
    ) i_issue_fifo (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .push    (dispatch),
        .push_op (push_op),
        .pop     (pop),
        .head_op (head_op),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    exec_unit i_exec_unit (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .empty   (fifo_empty),
        .head_op (head_op),
        .pop     (pop),
        .cdb     (cdb)
    );

    arch_reg_file i_arch_reg_file (
        .clk     (clk),
        .reset   (reset),
        .commit  (commit),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== rtl/ooo_pkg.sv ====
package ooo_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_len = 4;
    localparam int rob_size = 8;
    localparam int rob_tag_len = 3;

    // code 3 is unused and retires like fun_retire.
    typedef enum logic [1:0] {
        fun_wb     = 2'd0,
        fun_branch = 2'd1,
        fun_retire = 2'd2
    } fun_code_t;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_xor = 2'd2,
        alu_mul = 2'd3
    } alu_op_t;

    // this is the Wishbone write data word.
    typedef struct packed {
        fun_code_t               fun_code;
        alu_op_t                 alu_op;
        logic [reg_addr_len-1:0] dest;
        logic [xlen-1:0]         op_a;
        logic [xlen-1:0]         op_b;
    } dispatch_req_t;

    typedef struct packed {
        dispatch_req_t          req;
        logic [rob_tag_len-1:0] tag;
    } issue_op_t;

    typedef struct packed {
        logic                   valid;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        result;
    } cdb_t;

    typedef struct packed {
        logic                    wb_en;
        logic [reg_addr_len-1:0] wb_reg;
        logic [xlen-1:0]         wb_data;
    } commit_t;

    typedef struct packed {
        logic                    valid;
        logic                    ready;
        fun_code_t               fun_code;
        logic [reg_addr_len-1:0] wb_reg;
        logic [xlen-1:0]         wb_data;
    } rob_entry_t;

endpackage

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_size = ooo_pkg::rob_size
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dispatch,
    input  ooo_pkg::dispatch_req_t          dispatch_op,
    input  ooo_pkg::cdb_t                   cdb,
    output logic [ooo_pkg::rob_tag_len-1:0] rob_tag,
    output logic                            rob_full,
    output ooo_pkg::commit_t                commit,
    output logic                            flush
);

    import ooo_pkg::*;

    localparam int cnt_len = $clog2(rob_size + 1);
    localparam logic [rob_tag_len-1:0] last_ptr = rob_tag_len'(rob_size - 1);
    localparam logic [cnt_len-1:0] full_count = cnt_len'(rob_size);

    rob_entry_t             entries [rob_size];
    rob_entry_t             head_entry;
    logic [rob_tag_len-1:0] head;
    logic [rob_tag_len-1:0] tail;
    logic [cnt_len-1:0]     count;
    logic                   retire;

    function automatic logic [rob_tag_len-1:0] next_ptr(input logic [rob_tag_len-1:0] ptr);
        return (ptr == last_ptr) ? '0 : ptr + 1'b1;
    endfunction

    assign head_entry = entries[head];
    assign retire = head_entry.valid && head_entry.ready;

    assign commit.wb_en = retire && (head_entry.fun_code == fun_wb);
    assign commit.wb_reg = head_entry.wb_reg;
    assign commit.wb_data = head_entry.wb_data;

    // a branch whose result is zero is taken, so everything younger is discarded.
    assign flush = retire && (head_entry.fun_code == fun_branch) && (head_entry.wb_data == '0);

    assign rob_tag = tail;
    assign rob_full = (count == full_count);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (dispatch) begin
                entries[tail].valid <= 1'b1;
                entries[tail].ready <= 1'b0;
                entries[tail].fun_code <= dispatch_op.fun_code;
                entries[tail].wb_reg <= dispatch_op.dest;
                tail <= next_ptr(tail);
            end
            if (cdb.valid) begin
                entries[cdb.tag].ready <= 1'b1;
                entries[cdb.tag].wb_data <= cdb.result;
            end
            if (retire) begin
                entries[head].valid <= 1'b0;
                head <= next_ptr(head);
            end
            case ({dispatch, retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset)
        dispatch |-> !rob_full
    );

    // results must only come back for live ops that have not completed yet.
    a_cdb_names_pending_entry: assert property (
        @(posedge clk) disable iff (reset)
        cdb.valid |-> (entries[cdb.tag].valid && !entries[cdb.tag].ready)
    );

endmodule

// ==== tb.f ====
rtl/ooo_pkg.sv
rtl/dispatch_ctrl.sv
rtl/reorder_buffer.sv
rtl/issue_fifo.sv
rtl/exec_unit.sv
rtl/arch_reg_file.sv
rtl/ooo_core_top.sv
tests/tb_ooo_core.sv

// ==== tests/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;

    import ooo_pkg::*;

    localparam int clk_period = 40;
    localparam int rob_depth = 8;
    localparam int fifo_depth = 4;
    localparam int max_latency = 4;
    localparam int kind_wb = 0;
    localparam int kind_retire = 1;
    localparam int kind_branch = 2;
    localparam int kind_mul = 3;
    localparam int ops_per_test = 24;
    localparam int burst_ops = 40;
    // three mixed tests, one burst test and one closing writeback per test.
    localparam int total_ops = 3 * ops_per_test + burst_ops + 4;
    localparam int drain_limit = (rob_depth + fifo_depth) * max_latency * 4;
    localparam int time_limit = total_ops * max_latency * rob_depth * clk_period + 40000;

    logic                    clk;
    logic                    reset;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    dispatch_req_t           dat;
    logic                    ack;
    commit_t                 commit;
    logic                    flush;
    logic [reg_addr_len-1:0] rd_addr;
    logic [xlen-1:0]         rd_data;

    logic [31:0]     rng_state;
    dispatch_req_t   pending [$];
    logic [xlen-1:0] model_regs [16];
    string           test_name;
    int              errors;
    int              total_errors;
    int              tests_run;
    int              tests_failed;
    int              acked;
    int              committed;
    int              quiet_retired;
    int              discarded;
    int              flushes;

    ooo_core_top #(
        .rob_size   (rob_depth),
        .fifo_depth (fifo_depth)
    ) i_dut (
        .clk     (clk),
        .reset   (reset),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .dat     (dat),
        .ack     (ack),
        .commit  (commit),
        .flush   (flush),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(time_limit);
        $display("watchdog expired: the tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [xlen-1:0] expected_result(input dispatch_req_t req);
        case (req.alu_op)
            alu_add: return req.op_a + req.op_b;
            alu_sub: return req.op_a - req.op_b;
            alu_xor: return req.op_a ^ req.op_b;
            default: return req.op_a * req.op_b;
        endcase
    endfunction

    // retire-only ops and untaken branches leave the commit port quiet.
    function automatic logic is_silent(input dispatch_req_t req);
        if (req.fun_code == fun_wb) begin
            return 1'b0;
        end
        if (req.fun_code == fun_branch) begin
            return expected_result(req) != '0;
        end
        return 1'b1;
    endfunction

    function dispatch_req_t random_op(input int kind);
        dispatch_req_t req;
        logic [31:0]   r;
        r = rand_word();
        req.fun_code = fun_wb;
        req.alu_op = alu_op_t'(r[1:0]);
        req.dest = r[7:4];
        req.op_a = rand_word();
        req.op_b = rand_word();
        if (kind == kind_retire && r[8]) begin
            req.fun_code = fun_retire;
        end
        if (kind == kind_branch && r[9:8] == 2'b00) begin
            req.fun_code = fun_branch;
            req.alu_op = r[10] ? alu_sub : alu_xor;
            if (r[11]) begin
                req.op_b = req.op_a;
            end
        end
        if (kind == kind_mul) begin
            req.alu_op = alu_mul;
        end
        return req;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        errors++;
    endtask

    // matches one visible retirement against the oldest op the model still holds.
    task automatic check_retirement();
        dispatch_req_t   head;
        logic [xlen-1:0] result;
        while (pending.size() > 0 && is_silent(pending[0])) begin
            void'(pending.pop_front());
            quiet_retired++;
        end
        if (pending.size() == 0) begin
            report_problem("an operation retired with no accepted operation pending");
            return;
        end
        head = pending.pop_front();
        result = expected_result(head);
        if (flush) begin
            if (head.fun_code != fun_branch || result != '0) begin
                report_problem("flush was raised by an operation that is not a taken branch");
            end
            discarded += pending.size();
            pending.delete();
        end else if (head.fun_code != fun_wb) begin
            report_problem("a branch with a zero result retired without raising flush");
        end else begin
            if (commit.wb_reg !== head.dest) begin
                report_mismatch("wb_reg", xlen'(head.dest), xlen'(commit.wb_reg));
            end
            if (commit.wb_data !== result) begin
                report_mismatch("wb_data", result, commit.wb_data);
            end
            model_regs[head.dest] = result;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (commit.wb_en || flush) begin
                if (commit.wb_en) begin
                    committed++;
                end
                if (flush) begin
                    flushes++;
                end
                check_retirement();
            end
            if (ack) begin
                pending.push_back(dat);
                acked++;
            end
        end
    end

    task automatic send_op(input dispatch_req_t req);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        dat <= req;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        // the op is taken on this edge, and stb stays low for the next cycle.
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic finish_test();
        $display("test %-14s %s (%0d errors)", test_name, (errors == 0) ? "ok" : "failed",
                 errors);
        tests_run++;
        total_errors += errors;
        if (errors != 0) begin
            tests_failed++;
        end
    endtask

    task automatic read_registers();
        for (int r = 0; r < 16; r++) begin
            @(posedge clk);
            rd_addr <= reg_addr_len'(r);
            @(negedge clk);
            if (rd_data !== model_regs[r]) begin
                report_mismatch($sformatf("r%0d", r), model_regs[r], rd_data);
            end
        end
    endtask

    task automatic check_idle_outputs();
        if (ack !== 1'b0) begin
            report_mismatch("ack", '0, xlen'(ack));
        end
        if (commit.wb_en !== 1'b0) begin
            report_mismatch("wb_en", '0, xlen'(commit.wb_en));
        end
        if (flush !== 1'b0) begin
            report_mismatch("flush", '0, xlen'(flush));
        end
    endtask

    task automatic check_reset_state();
        test_name = "reset_state";
        errors = 0;
        repeat (15) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end
        read_registers();
        finish_test();
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int wait_cycles;
        test_name = name;
        errors = 0;
        acked = 0;
        committed = 0;
        quiet_retired = 0;
        discarded = 0;
        flushes = 0;
        for (int i = 0; i < count; i++) begin
            send_op(random_op(kind));
        end
        // a closing writeback pushes out any quiet retirements still in flight.
        send_op(random_op(kind_wb));
        wait_cycles = 0;
        while (pending.size() > 0 && wait_cycles < drain_limit) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending.size() > 0) begin
            report_problem("accepted operations never retired");
        end
        // commits and flushes are counted from the DUT's own outputs.
        if (acked != committed + flushes + quiet_retired + discarded) begin
            report_mismatch("op_count", acked, committed + flushes + quiet_retired + discarded);
        end
        if (kind == kind_branch && flushes == 0) begin
            report_problem("no branch was taken, so flush was never exercised");
        end
        finish_test();
    endtask

    initial begin
        rng_state = 32'd5;
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        dat = '0;
        rd_addr = '0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        check_reset_state();
        run_test("alu_writeback", kind_wb, ops_per_test);
        run_test("retire_only", kind_retire, ops_per_test);
        run_test("branch_flush", kind_branch, ops_per_test);
        run_test("back_pressure", kind_mul, burst_ops);
        test_name = "arch_state";
        errors = 0;
        read_registers();
        finish_test();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
